//--- Makefile
# tool, flags, top module and file list
TOOL      = verilator
FLAGS     = --binary --timing -j 0
TOP       = tb_top
FILELIST  = sim.f

LOG       = sim.log
FAIL_MSG  = Test failed
PASS_MSG  = Test passed
BIN       = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(wildcard *.sv) $(wildcard *.svh)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# the log decides the result, since tee hides the exit status
run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported errors"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- controller_core.sv
// command decoder, owns invert flags and sequence length, clears memories after reset
`timescale 1ns/1ps
`default_nettype none

module controller_core
  import driver_pkg::*;
(
  input  logic                   clock,
  input  logic                   reset_i,
  input  logic [CMD_W-1:0]       word_i,
  input  logic                   word_valid_i,
  input  logic                   control_trigger_i,
  input  logic                   latch_data_i,
  output logic                   word_ready_o,
  output logic [MEM_ADDR_W-1:0]  wr_addr_o,
  output logic [PIN_W-1:0]       wr_data_o,
  output logic [NUM_DRIVERS-1:0] wr_en_o,
  output logic [NUM_DRIVERS-1:0] invert_o,
  output logic [MEM_ADDR_W-1:0]  play_addr_o,
  output logic                   play_active_o,
  output logic                   update_cycle_complete_o
);

  logic                  clear_active;
  logic [MEM_ADDR_W-1:0] clear_addr;
  logic [MEM_ADDR_W:0]   seq_length;
  logic                  accept;
  opcode_e               opcode;
  logic [DRV_IDX_W-1:0]  drv_idx;
  logic [MEM_ADDR_W-1:0] cmd_addr;
  logic [MEM_ADDR_W-1:0] len_field;
  logic                  idx_ok;
  logic                  addr_ok;

  // field split
  assign opcode    = opcode_e'(word_i[OPC_MSB:OPC_LSB]);
  assign drv_idx   = word_i[IDX_MSB:IDX_LSB];
  assign cmd_addr  = word_i[ADDR_MSB:ADDR_LSB];
  assign len_field = word_i[LEN_DATA_LSB +: MEM_ADDR_W];

  assign idx_ok  = drv_idx < DRV_IDX_W'(NUM_DRIVERS);
  assign addr_ok = cmd_addr < MEM_ADDR_W'(MEM_LENGTH);

  // no commands while clearing or playing, the word waits in spi_rx
  assign word_ready_o = ~clear_active & ~play_active_o;
  assign accept       = word_valid_i & word_ready_o;

  // post-reset sweep writes zero to every entry of every driver
  always_ff @(posedge clock) begin
    if (reset_i) begin
      clear_active <= 1'b1;
      clear_addr   <= '0;
    end else if (clear_active) begin
      clear_addr <= clear_addr + 1'b1;
      if (clear_addr == MEM_ADDR_W'(MEM_LENGTH - 1)) begin
        clear_active <= 1'b0;
      end
    end
  end

  // write port, one cycle after the accepted word
  always_ff @(posedge clock) begin
    if (reset_i) begin
      wr_en_o <= '0;
    end else if (clear_active) begin
      wr_en_o <= '1;
    end else if (accept && opcode == OP_WRITE && idx_ok && addr_ok) begin
      wr_en_o <= NUM_DRIVERS'(1) << drv_idx;
    end else begin
      wr_en_o <= '0;
    end
  end

  always_ff @(posedge clock) begin
    if (clear_active) begin
      wr_addr_o <= clear_addr;
      wr_data_o <= '0;
    end else begin
      wr_addr_o <= cmd_addr;
      wr_data_o <= word_i[WR_DATA_LSB +: PIN_W];
    end
  end

  // invert flags and step count
  always_ff @(posedge clock) begin
    if (reset_i) begin
      invert_o   <= '0;
      seq_length <= (MEM_ADDR_W+1)'(MEM_LENGTH);
    end else if (accept) begin
      case (opcode)
        OP_SET_INVERT: begin
          if (idx_ok) begin
            invert_o[drv_idx] <= word_i[INV_BIT];
          end
        end
        OP_SET_LENGTH: begin
          // zero or too long falls back to the full memory
          if (len_field == '0 || len_field > MEM_ADDR_W'(MEM_LENGTH)) begin
            seq_length <= (MEM_ADDR_W+1)'(MEM_LENGTH);
          end else begin
            seq_length <= {1'b0, len_field};
          end
        end
        default: begin
          // nop, write and unknown codes leave these alone
        end
      endcase
    end
  end

  playback_sequencer i_sequencer (
    .clock                   (clock),
    .reset_i                 (reset_i),
    .control_trigger_i       (control_trigger_i),
    .latch_data_i            (latch_data_i),
    .seq_length_i            (seq_length),
    .play_addr_o             (play_addr_o),
    .play_active_o           (play_active_o),
    .update_cycle_complete_o (update_cycle_complete_o)
  );

endmodule

`default_nettype wire

//--- driver_core.sv
// one pin driver, pattern memory read at the playback address with invert and output enables
`timescale 1ns/1ps
`default_nettype none

module driver_core
  import driver_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset_i,
  input  logic                  wr_en_i,
  input  logic [MEM_ADDR_W-1:0] wr_addr_i,
  input  logic [PIN_W-1:0]      wr_data_i,
  input  logic                  invert_i,
  input  logic [MEM_ADDR_W-1:0] play_addr_i,
  input  logic                  play_active_i,
  output logic [PIN_W-1:0]      driver_io_o,
  output logic [PIN_W-1:0]      driver_oeb_o
);

  // pattern storage, zeroed by the controller sweep after reset
  logic [PIN_W-1:0] mem [MEM_LENGTH];
  logic [PIN_W-1:0] rd_data;
  logic [PIN_W-1:0] inv_mask;

  assign rd_data  = mem[play_addr_i];
  assign inv_mask = {PIN_W{invert_i}};

  // write port from the controller
  always_ff @(posedge clock) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // registered read straight to the pins
  // oeb is active low, so idle means released
  always_ff @(posedge clock) begin
    if (reset_i) begin
      driver_io_o  <= '0;
      driver_oeb_o <= '1;
    end else if (play_active_i) begin
      driver_io_o  <= rd_data ^ inv_mask;
      driver_oeb_o <= '0;
    end else begin
      driver_io_o  <= '0;
      driver_oeb_o <= '1;
    end
  end

endmodule

`default_nettype wire

//--- driver_pkg.sv
// shared sizes, opcode and state enums, command field positions; import into every rtl module
`default_nettype none

package driver_pkg;

  // array sizes
  localparam int NUM_DRIVERS = 10;
  localparam int MEM_LENGTH  = 48;
  localparam int MEM_ADDR_W  = 6;
  localparam int PIN_W       = 2;

  // spi command word
  localparam int CMD_W       = 32;
  localparam int DRV_IDX_W   = 4;
  // bit counter wide enough to hold CMD_W and saturate above it
  localparam int BIT_CNT_W   = 6;

  // input synchronizer depth
  localparam int SYNC_STAGES = 2;

  // command word field positions
  localparam int OPC_MSB  = 31;
  localparam int OPC_LSB  = 28;
  localparam int IDX_MSB  = 27;
  localparam int IDX_LSB  = 24;
  localparam int ADDR_MSB = 21;
  localparam int ADDR_LSB = 16;

  // used data bits per opcode
  localparam int WR_DATA_LSB  = 0;
  localparam int INV_BIT      = 0;
  localparam int LEN_DATA_LSB = 0;

  typedef enum logic [3:0] {
    OP_NOP        = 4'h0,
    OP_WRITE      = 4'h1,
    OP_SET_INVERT = 4'h2,
    OP_SET_LENGTH = 4'h3
  } opcode_e;

  typedef enum logic {
    SEQ_IDLE = 1'b0,
    SEQ_PLAY = 1'b1
  } seq_state_e;

endpackage

`default_nettype wire

//--- driver_top.sv
// top level, spi receiver into the controller and a row of driver cores
`timescale 1ns/1ps
`default_nettype none

module driver_top
  import driver_pkg::*;
(
  input  logic                         clock,
  input  logic                         reset_i,
  input  logic                         sclk_i,
  input  logic                         mosi_i,
  input  logic                         ss_n_i,
  input  logic                         control_trigger_i,
  input  logic                         latch_data_i,
  output logic [NUM_DRIVERS*PIN_W-1:0] driver_io_o,
  output logic [NUM_DRIVERS*PIN_W-1:0] driver_oeb_o,
  output logic                         update_cycle_complete_o
);

  // spi to controller handshake
  logic [CMD_W-1:0]       word;
  logic                   word_valid;
  logic                   word_ready;

  // controller to drivers
  logic [MEM_ADDR_W-1:0]  wr_addr;
  logic [PIN_W-1:0]       wr_data;
  logic [NUM_DRIVERS-1:0] wr_en;
  logic [NUM_DRIVERS-1:0] invert;
  logic [MEM_ADDR_W-1:0]  play_addr;
  logic                   play_active;

  spi_rx i_spi_rx (
    .clock        (clock),
    .reset_i      (reset_i),
    .sclk_i       (sclk_i),
    .mosi_i       (mosi_i),
    .ss_n_i       (ss_n_i),
    .word_ready_i (word_ready),
    .word_o       (word),
    .word_valid_o (word_valid)
  );

  controller_core i_controller (
    .clock                   (clock),
    .reset_i                 (reset_i),
    .word_i                  (word),
    .word_valid_i            (word_valid),
    .control_trigger_i       (control_trigger_i),
    .latch_data_i            (latch_data_i),
    .word_ready_o            (word_ready),
    .wr_addr_o               (wr_addr),
    .wr_data_o               (wr_data),
    .wr_en_o                 (wr_en),
    .invert_o                (invert),
    .play_addr_o             (play_addr),
    .play_active_o           (play_active),
    .update_cycle_complete_o (update_cycle_complete_o)
  );

  // driver g owns pins [g*PIN_W +: PIN_W]
  for (genvar g = 0; g < NUM_DRIVERS; g++) begin : g_driver
    driver_core i_driver (
      .clock         (clock),
      .reset_i       (reset_i),
      .wr_en_i       (wr_en[g]),
      .wr_addr_i     (wr_addr),
      .wr_data_i     (wr_data),
      .invert_i      (invert[g]),
      .play_addr_i   (play_addr),
      .play_active_i (play_active),
      .driver_io_o   (driver_io_o[g*PIN_W +: PIN_W]),
      .driver_oeb_o  (driver_oeb_o[g*PIN_W +: PIN_W])
    );
  end

endmodule

`default_nettype wire

//--- playback_sequencer.sv
// steps the playback address on latch rises after a trigger, pulses update-complete at the end
`timescale 1ns/1ps
`default_nettype none

module playback_sequencer
  import driver_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset_i,
  input  logic                  control_trigger_i,
  input  logic                  latch_data_i,
  input  logic [MEM_ADDR_W:0]   seq_length_i,
  output logic [MEM_ADDR_W-1:0] play_addr_o,
  output logic                  play_active_o,
  output logic                  update_cycle_complete_o
);

  // two bits per stage: {trigger, latch}
  logic [2*SYNC_STAGES-1:0] sync_q;
  logic                     trig_s;
  logic                     latch_s;
  logic                     trig_prev;
  logic                     latch_prev;
  logic                     trig_rise;
  logic                     latch_rise;
  logic                     last_step;
  seq_state_e               state;

  assign trig_s     = sync_q[2*SYNC_STAGES-1];
  assign latch_s    = sync_q[2*SYNC_STAGES-2];
  assign trig_rise  = trig_s & ~trig_prev;
  assign latch_rise = latch_s & ~latch_prev;

  assign last_step     = {1'b0, play_addr_o} == seq_length_i - 1'b1;
  assign play_active_o = state == SEQ_PLAY;

  always_ff @(posedge clock) begin
    if (reset_i) begin
      sync_q     <= '0;
      trig_prev  <= 1'b0;
      latch_prev <= 1'b0;
    end else begin
      sync_q     <= {sync_q[2*SYNC_STAGES-3:0], control_trigger_i, latch_data_i};
      trig_prev  <= trig_s;
      latch_prev <= latch_s;
    end
  end

  always_ff @(posedge clock) begin
    if (reset_i) begin
      state                   <= SEQ_IDLE;
      play_addr_o             <= '0;
      update_cycle_complete_o <= 1'b0;
    end else begin
      update_cycle_complete_o <= 1'b0;
      case (state)
        SEQ_IDLE: begin
          play_addr_o <= '0;
          if (trig_rise) begin
            state <= SEQ_PLAY;
          end
        end
        SEQ_PLAY: begin
          // trigger ignored here, only latch moves the step
          if (latch_rise) begin
            if (last_step) begin
              state                   <= SEQ_IDLE;
              play_addr_o             <= '0;
              update_cycle_complete_o <= 1'b1;
            end else begin
              play_addr_o <= play_addr_o + 1'b1;
            end
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+.
driver_pkg.sv
spi_rx.sv
playback_sequencer.sv
controller_core.sv
driver_core.sv
driver_top.sv
tb_top.sv

//--- spi_rx.sv
// spi mode 0 target, collects 32-bit msb-first words and hands them on with valid/ready
`timescale 1ns/1ps
`default_nettype none

module spi_rx
  import driver_pkg::*;
(
  input  logic             clock,
  input  logic             reset_i,
  input  logic             sclk_i,
  input  logic             mosi_i,
  input  logic             ss_n_i,
  input  logic             word_ready_i,
  output logic [CMD_W-1:0] word_o,
  output logic             word_valid_o
);

  // synchronizer chain, three bits per stage: {ss_n, sclk, mosi}
  logic [3*SYNC_STAGES-1:0] sync_q;
  logic                     ss_n_s;
  logic                     sclk_s;
  logic                     mosi_s;
  logic                     sclk_prev;
  logic                     ss_n_prev;
  logic                     sclk_rise;
  logic                     frame_end;
  logic [CMD_W-1:0]         shift_q;
  logic [BIT_CNT_W-1:0]     bit_cnt;

  // oldest stage is the synchronized value
  assign ss_n_s = sync_q[3*SYNC_STAGES-1];
  assign sclk_s = sync_q[3*SYNC_STAGES-2];
  assign mosi_s = sync_q[3*SYNC_STAGES-3];

  assign sclk_rise = sclk_s & ~sclk_prev;
  // ss_n going high closes the frame
  assign frame_end = ss_n_s & ~ss_n_prev;

  always_ff @(posedge clock) begin
    if (reset_i) begin
      // idle bus: ss_n high, sclk low
      sync_q    <= {SYNC_STAGES{3'b100}};
      sclk_prev <= 1'b0;
      ss_n_prev <= 1'b1;
    end else begin
      sync_q    <= {sync_q[3*SYNC_STAGES-4:0], ss_n_i, sclk_i, mosi_i};
      sclk_prev <= sclk_s;
      ss_n_prev <= ss_n_s;
    end
  end

  // shift register, msb first
  always_ff @(posedge clock) begin
    if (sclk_rise && !ss_n_s) begin
      shift_q <= {shift_q[CMD_W-2:0], mosi_s};
    end
  end

  // bit count, saturates so long frames never wrap back to 32
  always_ff @(posedge clock) begin
    if (reset_i || ss_n_s) begin
      bit_cnt <= '0;
    end else if (sclk_rise && bit_cnt != '1) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // one-word buffer
  always_ff @(posedge clock) begin
    if (reset_i) begin
      word_valid_o <= 1'b0;
    end else if (word_valid_o) begin
      // held until accepted, a frame finishing meanwhile is lost
      if (word_ready_i) begin
        word_valid_o <= 1'b0;
      end
    end else if (frame_end && bit_cnt == BIT_CNT_W'(CMD_W)) begin
      word_valid_o <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (!word_valid_o && frame_end) begin
      word_o <= shift_q;
    end
  end

endmodule

`default_nettype wire

//--- tb_tasks.svh
// spi frame, trigger, latch, wait and compare tasks that tb_top includes

  // every step below starts and ends on a falling edge
  task automatic wait_clocks(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clock);
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      test_errors++;
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // mode 0 and msb first with mosi set while sclk is low
  // a short frame carries only the low nbits of the word
  task automatic send_spi_frame(input logic [31:0] word, input int nbits);
    ss_n_i = 1'b0;
    wait_clocks(SPI_HALF);
    for (int i = 0; i < nbits; i++) begin
      mosi_i = word[nbits - 1 - i];
      wait_clocks(SPI_HALF);
      sclk_i = 1'b1;
      wait_clocks(SPI_HALF);
      sclk_i = 1'b0;
    end
    wait_clocks(SPI_HALF);
    // rise of ss_n closes the frame
    ss_n_i = 1'b1;
    mosi_i = 1'b0;
  endtask

  // trigger stays high until the enables drop
  task automatic fire_trigger();
    int waited;
    control_trigger_i = 1'b1;
    waited            = 0;
    while (driver_oeb_o !== '0 && waited < WAIT_LIMIT) begin
      @(negedge clock);
      waited++;
    end
    if (driver_oeb_o !== '0) begin
      error_count++;
      test_errors++;
      $display("Timeout: drivers not enabled %0d clocks after the trigger rose", WAIT_LIMIT);
    end
    control_trigger_i = 1'b0;
    // trigger low again before the pins are checked
    wait_clocks(SPI_HALF);
  endtask

  // pins are read LATCH_CHECK clocks after the latch rise
  task automatic pulse_latch();
    latch_data_i = 1'b1;
    wait_clocks(LATCH_HIGH);
    latch_data_i = 1'b0;
    wait_clocks(LATCH_CHECK - LATCH_HIGH);
  endtask

//--- tb_top.sv
// testbench for driver_top that builds a command table from a reference model and checks every pin
`timescale 1ns/1ps
`default_nettype none

module tb_top
  import driver_pkg::*;
();

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 16;
  localparam int CLEAR_CYCLES = 60;
  localparam int SPI_HALF     = 4;
  localparam int LATCH_HIGH   = 4;
  localparam int LATCH_CHECK  = 8;
  localparam int CMD_SETTLE   = 10;
  localparam int WAIT_LIMIT   = 20;
  localparam int NUM_TESTS    = 6;
  localparam int PASS_STEPS   = 4;

  // row actions
  localparam int ACT_CMD   = 0;
  localparam int ACT_TRIG  = 1;
  localparam int ACT_LATCH = 2;
  localparam int ACT_WAIT  = 3;

  logic                         clock;
  logic                         reset_i;
  logic                         sclk_i;
  logic                         mosi_i;
  logic                         ss_n_i;
  logic                         control_trigger_i;
  logic                         latch_data_i;
  logic [NUM_DRIVERS*PIN_W-1:0] driver_io_o;
  logic [NUM_DRIVERS*PIN_W-1:0] driver_oeb_o;
  logic                         update_cycle_complete_o;

  // row_arg holds the frame bit count or the wait length
  int          row_test[$];
  int          row_act[$];
  logic [31:0] row_word[$];
  int          row_arg[$];
  logic        row_done[$];
  string       test_name [NUM_TESTS] = '{"reset state", "write and play", "invert",
                                         "ignored commands", "bad frame", "back-pressure"};

  // reference model of the pattern state
  logic [PIN_W-1:0]       model_mem [NUM_DRIVERS][MEM_LENGTH];
  logic [NUM_DRIVERS-1:0] model_inv;
  int                     model_len;
  logic                   model_playing;
  int                     model_step;
  // word held in the receiver while playing
  logic                   pend_valid;
  logic [31:0]            pend_word;

  int check_count  = 0;
  int error_count  = 0;
  int test_errors  = 0;
  int failed_tests = 0;
  int done_pulses  = 0;
  int pulse_base   = 0;

  driver_top i_dut (
    .clock                   (clock),
    .reset_i                 (reset_i),
    .sclk_i                  (sclk_i),
    .mosi_i                  (mosi_i),
    .ss_n_i                  (ss_n_i),
    .control_trigger_i       (control_trigger_i),
    .latch_data_i            (latch_data_i),
    .driver_io_o             (driver_io_o),
    .driver_oeb_o            (driver_oeb_o),
    .update_cycle_complete_o (update_cycle_complete_o)
  );

  `include "tb_tasks.svh"

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  // counts each clock the completion pulse is high
  always @(posedge clock) begin
    if (update_cycle_complete_o === 1'b1) begin
      done_pulses++;
    end
  end

  // fields are opcode, index, two spare bits, address and data
  function automatic logic [31:0] make_word(input logic [3:0] op, input int idx,
                                            input int addr, input int data);
    return {op, idx[3:0], 2'b00, addr[5:0], data[15:0]};
  endfunction

  function automatic void add_row(input int test, input int act, input logic [31:0] word,
                                  input int arg, input logic done);
    row_test.push_back(test);
    row_act.push_back(act);
    row_word.push_back(word);
    row_arg.push_back(arg);
    row_done.push_back(done);
  endfunction

  // trigger plus one latch per step where the last latch completes the pass
  function automatic void add_pass(input int test);
    add_row(test, ACT_TRIG, '0, 0, 1'b0);
    for (int s = 0; s < PASS_STEPS; s++) begin
      add_row(test, ACT_LATCH, '0, 0, s == PASS_STEPS - 1);
    end
  endfunction

  function automatic void model_command(input logic [31:0] word);
    logic [3:0] op;
    int         idx;
    int         addr;
    int         len;
    op   = word[31:28];
    idx  = int'(word[27:24]);
    addr = int'(word[21:16]);
    len  = int'(word[5:0]);
    if (op == OP_WRITE) begin
      if (idx < NUM_DRIVERS && addr < MEM_LENGTH) begin
        model_mem[idx][addr] = word[1:0];
      end
    end else if (op == OP_SET_INVERT) begin
      if (idx < NUM_DRIVERS) begin
        model_inv[idx] = word[0];
      end
    end else if (op == OP_SET_LENGTH) begin
      model_len = (len == 0 || len > MEM_LENGTH) ? MEM_LENGTH : len;
    end
  endfunction

  // a full frame during playback waits in the one-word buffer and a second one is lost
  function automatic void model_receive(input logic [31:0] word);
    if (!model_playing) begin
      model_command(word);
    end else if (!pend_valid) begin
      pend_word  = word;
      pend_valid = 1'b1;
    end
  endfunction

  function automatic void model_latch();
    if (model_playing) begin
      if (model_step == model_len - 1) begin
        model_playing = 1'b0;
        model_step    = 0;
        // held word goes in as soon as playback stops
        if (pend_valid) begin
          model_command(pend_word);
          pend_valid = 1'b0;
        end
      end else begin
        model_step++;
      end
    end
  endfunction

  task automatic check_outputs(input logic exp_done);
    logic [NUM_DRIVERS*PIN_W-1:0] exp_io;
    logic [NUM_DRIVERS*PIN_W-1:0] exp_oeb;
    exp_io  = '0;
    exp_oeb = '1;
    if (model_playing) begin
      exp_oeb = '0;
      for (int d = 0; d < NUM_DRIVERS; d++) begin
        exp_io[d*PIN_W +: PIN_W] = model_mem[d][model_step] ^ {PIN_W{model_inv[d]}};
      end
    end
    check_value("driver_io_o", 32'(driver_io_o), 32'(exp_io));
    check_value("driver_oeb_o", 32'(driver_oeb_o), 32'(exp_oeb));
    check_value("update_cycle_complete_o pulses", done_pulses - pulse_base, 32'(exp_done));
  endtask

  task automatic build_table();
    logic [1:0] gen [NUM_DRIVERS][PASS_STEPS];
    logic [1:0] flip;
    add_row(1, ACT_WAIT, '0, 4, 1'b0);
    // random pairs at the first four entries of every driver
    for (int d = 0; d < NUM_DRIVERS; d++) begin
      for (int a = 0; a < PASS_STEPS; a++) begin
        gen[d][a] = 2'($urandom());
        add_row(2, ACT_CMD, make_word(OP_WRITE, d, a, int'(gen[d][a])), CMD_W, 1'b0);
      end
    end
    add_row(2, ACT_CMD, make_word(OP_SET_LENGTH, 0, 0, PASS_STEPS), CMD_W, 1'b0);
    add_pass(2);
    add_row(3, ACT_CMD, make_word(OP_SET_INVERT, 2, 0, 1), CMD_W, 1'b0);
    add_row(3, ACT_CMD, make_word(OP_SET_INVERT, 7, 0, 1), CMD_W, 1'b0);
    add_pass(3);
    // unknown opcode first, then bad index and bad address
    flip = ~gen[1][0];
    add_row(4, ACT_CMD, make_word(4'h9, 1, 0, int'(flip)), CMD_W, 1'b0);
    add_row(4, ACT_CMD, make_word(OP_WRITE, 12, 0, 3), CMD_W, 1'b0);
    // data ends in 0 so the last bit shifted in before the short frame is 0
    add_row(4, ACT_CMD, make_word(OP_WRITE, 0, 50, 2), CMD_W, 1'b0);
    add_pass(4);
    // 31-bit frame that decodes as a real write if the receiver keeps it
    flip = ~gen[3][1];
    add_row(5, ACT_CMD, make_word(OP_WRITE, 3, 1, int'(flip)), CMD_W - 1, 1'b0);
    flip = ~gen[4][2];
    add_row(5, ACT_CMD, make_word(OP_WRITE, 4, 2, int'(flip)), CMD_W, 1'b0);
    add_pass(5);
    // write sent mid-pass shows up only in the next one
    flip = ~gen[5][2];
    add_row(6, ACT_TRIG, '0, 0, 1'b0);
    add_row(6, ACT_LATCH, '0, 0, 1'b0);
    add_row(6, ACT_CMD, make_word(OP_WRITE, 5, 2, int'(flip)), CMD_W, 1'b0);
    add_row(6, ACT_LATCH, '0, 0, 1'b0);
    add_row(6, ACT_LATCH, '0, 0, 1'b0);
    add_row(6, ACT_LATCH, '0, 0, 1'b1);
    add_pass(6);
  endtask

  task automatic run_row(input int r);
    pulse_base = done_pulses;
    case (row_act[r])
      ACT_CMD: begin
        send_spi_frame(row_word[r], row_arg[r]);
        // short frames never reach the controller
        if (row_arg[r] == CMD_W) begin
          model_receive(row_word[r]);
        end
        wait_clocks(CMD_SETTLE);
      end
      ACT_TRIG: begin
        if (!model_playing) begin
          model_playing = 1'b1;
          model_step    = 0;
        end
        fire_trigger();
      end
      ACT_LATCH: begin
        pulse_latch();
        model_latch();
      end
      default: begin
        wait_clocks(row_arg[r]);
      end
    endcase
    check_outputs(row_done[r]);
  endtask

  task automatic report_test(input int id);
    if (test_errors == 0) begin
      $display("test %0d %s: ok", id, test_name[id-1]);
    end else begin
      failed_tests++;
      $display("test %0d %s: FAIL with %0d errors", id, test_name[id-1], test_errors);
    end
    test_errors = 0;
  endtask

  initial begin
    int cur_test;
    void'($urandom(32'h3808));
    reset_i           = 1'b1;
    sclk_i            = 1'b0;
    mosi_i            = 1'b0;
    ss_n_i            = 1'b1;
    control_trigger_i = 1'b0;
    latch_data_i      = 1'b0;
    // model matches the state after the clear sweep
    for (int d = 0; d < NUM_DRIVERS; d++) begin
      for (int a = 0; a < MEM_LENGTH; a++) begin
        model_mem[d][a] = '0;
      end
    end
    model_inv     = '0;
    model_len     = MEM_LENGTH;
    model_playing = 1'b0;
    model_step    = 0;
    pend_valid    = 1'b0;
    pend_word     = '0;
    build_table();
    wait_clocks(RESET_CYCLES);
    reset_i = 1'b0;
    wait_clocks(CLEAR_CYCLES);
    cur_test = row_test[0];
    for (int r = 0; r < row_act.size(); r++) begin
      if (row_test[r] != cur_test) begin
        report_test(cur_test);
        cur_test = row_test[r];
      end
      run_row(r);
    end
    report_test(cur_test);
    $display("summary: %0d tests, %0d with errors, %0d checks, %0d errors",
             NUM_TESTS, failed_tests, check_count, error_count);
    if (error_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
